// File: bench/orange_golden.txt
# p colour_hex repeat | r direction(0 none 1 left 2 right 3 center) count odd_byte
# f frame_count detected | rows of 16 pixels, left 0-4, center 5-14, right 15
p c44 2
p c95 1
p c90 2
p b64 5
p ca4 5
p c34 1
r 1 4 0
p 000 5
p f64 10
p 000 1
r 3 10 0
p 000 15
p f64 1
r 2 1 1
p f64 1
p 000 14
p f64 1
r 0 2 0
f 17 1
p f64 5
p 000 11
r 1 5 0
p 000 5
p f64 4
p 000 7
r 3 4 0
p 000 5
p f64 4
p 000 6
p f64 1
r 2 5 0
p f64 1
p 000 14
p f64 1
r 0 2 1
f 16 0

// File: verilog.f
logic/pixel_pkg.sv
logic/steer_pkg.sv
logic/pixel_capture.sv
logic/orange_detect.sv
logic/zone_classifier.sv
logic/result_queue.sv
logic/orange_tracker_top.sv
bench/tb_orange_tracker.sv

// File: Makefile
SIM := obj_dir/Vtb_orange_tracker

.PHONY: all run clean

all: run

$(SIM): verilog.f $(wildcard logic/*.sv bench/*.sv)
	verilator --binary --timing --assert --timescale 1ns/100ps -j 0 \
		--top-module tb_orange_tracker -Mdir obj_dir -f verilog.f

run: $(SIM) bench/orange_golden.txt
	./$(SIM) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Finished with errors" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "Finished with no errors" sim.log || { echo "simulation did not finish"; exit 1; }

clean:
	rm -rf obj_dir sim.log

// File: bench/tb_orange_tracker.sv
`timescale 1ns/100ps

module tb_orange_tracker;

    localparam int queue_depth     = 4;
    localparam int initial_credits = 2;
    localparam int cw              = steer_pkg::count_width;
    // cycle budget for every wait loop
    localparam int wait_limit      = 4000;

    logic                    clk;
    logic                    rst_n;
    logic [7:0]              cam_data;
    logic                    href;
    logic                    vsync;
    logic                    credit_return;
    logic                    out_valid;
    steer_pkg::result_kind_t out_kind;
    steer_pkg::direction_t   out_direction;
    logic [cw-1:0]           out_count;
    logic                    out_detected;
    logic                    overflow;

    // expected results in leaving order
    // packed as kind, direction, count, detected
    logic [cw+4:0] exp_q[$];
    string         name_q[$];
    // initial credits plus returns minus results seen
    int            credit_tally;

    orange_tracker_top #(
        .frame_width     (16),
        .frame_height    (4),
        .left_end        (5),
        .right_start     (15),
        .queue_depth     (queue_depth),
        .initial_credits (initial_credits)
    ) DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .cam_data      (cam_data),
        .href          (href),
        .vsync         (vsync),
        .credit_return (credit_return),
        .out_valid     (out_valid),
        .out_kind      (out_kind),
        .out_direction (out_direction),
        .out_count     (out_count),
        .out_detected  (out_detected),
        .overflow      (overflow)
    );

    // 100 ns clock
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_stop(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic compare_field(input string name, input string field,
                                 input int expected, input int actual);
        assert (expected == actual) else
            fail_stop($sformatf("mismatch %s %s expected %0d actual %0d",
                                name, field, expected, actual));
    endtask

    // one result leaving the queue is checked against the oldest expectation
    task automatic check_result();
        logic [cw+4:0] expected;
        string         name;
        assert (exp_q.size() > 0) else
            fail_stop("a result arrived that the golden file does not expect");
        assert (credit_tally > 0) else
            fail_stop("a result arrived while no credit was outstanding");
        expected     = exp_q.pop_front();
        name         = name_q.pop_front();
        credit_tally = credit_tally - 1;
        compare_field(name, "kind", int'(expected[cw+4]), int'(out_kind));
        compare_field(name, "direction", int'(expected[cw+3:cw+1]), int'(out_direction));
        compare_field(name, "count", int'(expected[cw:1]), int'(out_count));
        compare_field(name, "detected", int'(expected[0]), int'(out_detected));
    endtask

    // outputs sampled before the edge updates them
    always @(posedge clk) begin
        if (!rst_n) begin
            credit_tally = initial_credits;
        end else begin
            if (out_valid) begin
                check_result();
            end
            if (credit_return) begin
                credit_tally = credit_tally + 1;
            end
        end
    end

    task automatic send_byte(input logic [7:0] value);
        @(posedge clk);
        cam_data <= value;
        href     <= 1'b1;
    endtask

    // high byte first with the top nibble unused
    task automatic send_pixel(input logic [11:0] colour);
        send_byte({4'h0, colour[11:8]});
        send_byte(colour[7:0]);
    endtask

    // an odd trailing byte must not shift the next row
    task automatic end_row(input int odd);
        if (odd != 0) begin
            send_byte(8'h5a);
        end
        @(posedge clk);
        href <= 1'b0;
        repeat (4) @(posedge clk);
    endtask

    task automatic pulse_vsync();
        @(posedge clk);
        vsync <= 1'b1;
        repeat (3) @(posedge clk);
        vsync <= 1'b0;
        repeat (4) @(posedge clk);
    endtask

    // keep outstanding results below queue_depth before the next row
    task automatic settle_backlog(input string after);
        int cycles;
        cycles = 0;
        while (exp_q.size() > queue_depth - 2 && cycles < wait_limit) begin
            @(posedge clk);
            cycles++;
        end
        assert (exp_q.size() <= queue_depth - 2) else
            fail_stop($sformatf("results after %s backed up, credits stopped coming", after));
    endtask

    // random credit returns with long gaps
    initial begin
        int gap;
        void'($urandom(32'h16a0));
        repeat (12) @(posedge clk);
        forever begin
            gap = $urandom % 48;
            repeat (gap) @(posedge clk);
            credit_return <= 1'b1;
            @(posedge clk);
            credit_return <= 1'b0;
        end
    end

    initial begin
        int          fd;
        int          n;
        int          count;
        int          dir;
        int          extra;
        int          row_idx;
        int          frame_idx;
        int          cycles;
        string       line;
        string       name;
        logic [7:0]  tag;
        logic [11:0] colour;
        rst_n         = 1'b0;
        cam_data      = 8'h00;
        href          = 1'b0;
        vsync         = 1'b0;
        credit_return = 1'b0;
        row_idx       = 0;
        frame_idx     = 0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        fd = $fopen("bench/orange_golden.txt", "r");
        assert (fd != 0) else
            fail_stop("cannot open bench/orange_golden.txt");
        n = $fgets(line, fd);
        while (n != 0) begin
            // comment lines start with #
            if (line.getc(0) != "#") begin
                tag = 8'h00;
                void'($sscanf(line, "%c", tag));
                case (tag)
                    "p": begin
                        void'($sscanf(line, "%c %h %d", tag, colour, count));
                        repeat (count) send_pixel(colour);
                    end
                    "r": begin
                        void'($sscanf(line, "%c %d %d %d", tag, dir, count, extra));
                        row_idx++;
                        name = $sformatf("row_%0d", row_idx);
                        exp_q.push_back({steer_pkg::kind_row, 3'(dir), cw'(count), 1'b0});
                        name_q.push_back(name);
                        end_row(extra);
                        settle_backlog(name);
                    end
                    "f": begin
                        void'($sscanf(line, "%c %d %d", tag, count, extra));
                        frame_idx++;
                        name = $sformatf("frame_%0d", frame_idx);
                        exp_q.push_back({steer_pkg::kind_frame, steer_pkg::dir_none,
                                         cw'(count), 1'(extra)});
                        name_q.push_back(name);
                        pulse_vsync();
                        settle_backlog(name);
                    end
                    default: begin
                        // blank line
                    end
                endcase
            end
            n = $fgets(line, fd);
        end
        $fclose(fd);

        // drain the remaining results
        cycles = 0;
        while (exp_q.size() > 0 && cycles < wait_limit) begin
            @(posedge clk);
            cycles++;
        end
        assert (exp_q.size() == 0) else
            fail_stop($sformatf("result %s never arrived", name_q[0]));
        // a few more cycles so a stray result would show up
        repeat (20) @(posedge clk);
        assert (overflow == 1'b0) else
            fail_stop("overflow is set, a result was dropped");
        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: logic/orange_tracker_top.sv
`timescale 1ns/100ps

module orange_tracker_top #(
    parameter int frame_width     = 320,
    parameter int frame_height    = 240,
    parameter int left_end        = 100,
    parameter int right_start     = 295,
    parameter int queue_depth     = 4,
    parameter int initial_credits = 2
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [7:0]                        cam_data,
    input  logic                              href,
    input  logic                              vsync,
    input  logic                              credit_return,
    output logic                              out_valid,
    output steer_pkg::result_kind_t           out_kind,
    output steer_pkg::direction_t             out_direction,
    output logic [steer_pkg::count_width-1:0] out_count,
    output logic                              out_detected,
    output logic                              overflow
);

    // capture to detect
    logic                   pix_valid;
    pixel_pkg::pixel_word_t pix_word;
    logic                   line_active;
    logic                   frame_end;

    // detect to classifier
    logic pix_valid_q;
    logic is_orange;
    logic line_active_q;
    logic frame_end_q;

    // classifier to queue
    logic                              res_valid;
    steer_pkg::result_kind_t           res_kind;
    steer_pkg::direction_t             res_direction;
    logic [steer_pkg::count_width-1:0] res_count;
    logic                              res_detected;

    pixel_capture u_capture (
        .clk         (clk),
        .rst_n       (rst_n),
        .cam_data    (cam_data),
        .href        (href),
        .vsync       (vsync),
        .pix_valid   (pix_valid),
        .pix_word    (pix_word),
        .line_active (line_active),
        .frame_end   (frame_end)
    );

    orange_detect u_detect (
        .clk           (clk),
        .rst_n         (rst_n),
        .pix_valid     (pix_valid),
        .pix_word      (pix_word),
        .line_active   (line_active),
        .frame_end     (frame_end),
        .pix_valid_q   (pix_valid_q),
        .is_orange     (is_orange),
        .line_active_q (line_active_q),
        .frame_end_q   (frame_end_q)
    );

    zone_classifier #(
        .frame_width  (frame_width),
        .frame_height (frame_height),
        .left_end     (left_end),
        .right_start  (right_start)
    ) u_classifier (
        .clk           (clk),
        .rst_n         (rst_n),
        .pix_valid     (pix_valid_q),
        .is_orange     (is_orange),
        .line_active   (line_active_q),
        .frame_end     (frame_end_q),
        .res_valid     (res_valid),
        .res_kind      (res_kind),
        .res_direction (res_direction),
        .res_count     (res_count),
        .res_detected  (res_detected)
    );

    result_queue #(
        .queue_depth     (queue_depth),
        .initial_credits (initial_credits)
    ) u_queue (
        .clk           (clk),
        .rst_n         (rst_n),
        .res_valid     (res_valid),
        .res_kind      (res_kind),
        .res_direction (res_direction),
        .res_count     (res_count),
        .res_detected  (res_detected),
        .credit_return (credit_return),
        .out_valid     (out_valid),
        .out_kind      (out_kind),
        .out_direction (out_direction),
        .out_count     (out_count),
        .out_detected  (out_detected),
        .overflow      (overflow)
    );

endmodule

// File: logic/result_queue.sv
`timescale 1ns/100ps

module result_queue #(
    parameter int queue_depth     = 4,
    parameter int initial_credits = 2
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              res_valid,
    input  steer_pkg::result_kind_t           res_kind,
    input  steer_pkg::direction_t             res_direction,
    input  logic [steer_pkg::count_width-1:0] res_count,
    input  logic                              res_detected,
    input  logic                              credit_return,
    output logic                              out_valid,
    output steer_pkg::result_kind_t           out_kind,
    output steer_pkg::direction_t             out_direction,
    output logic [steer_pkg::count_width-1:0] out_count,
    output logic                              out_detected,
    output logic                              overflow
);

    localparam int ptr_width    = (queue_depth > 1) ? $clog2(queue_depth) : 1;
    localparam int occ_width    = $clog2(queue_depth + 1);
    localparam int credit_width = 8;

    // one storage array per result field
    steer_pkg::result_kind_t           kind_mem  [queue_depth];
    steer_pkg::direction_t             dir_mem   [queue_depth];
    logic [steer_pkg::count_width-1:0] count_mem [queue_depth];
    logic                              det_mem   [queue_depth];

    logic [ptr_width-1:0]    wr_ptr;
    logic [ptr_width-1:0]    rd_ptr;
    logic [occ_width-1:0]    occupancy;
    logic [credit_width-1:0] credits;
    logic                    full;
    logic                    send;
    logic                    accept;

    assign full   = occupancy == occ_width'(queue_depth);
    // a result leaves only with a credit in hand
    assign send   = (credits != '0) && (occupancy != '0);
    // a full queue still takes a result if one leaves in the same cycle
    assign accept = res_valid && (!full || send);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
            credits   <= credit_width'(initial_credits);
            out_valid <= 1'b0;
            overflow  <= 1'b0;
        end else begin
            out_valid <= send;
            if (accept) begin
                wr_ptr <= (wr_ptr == ptr_width'(queue_depth - 1)) ? '0 : wr_ptr + ptr_width'(1);
            end
            if (send) begin
                rd_ptr <= (rd_ptr == ptr_width'(queue_depth - 1)) ? '0 : rd_ptr + ptr_width'(1);
            end
            case ({accept, send})
                2'b10:   occupancy <= occupancy + occ_width'(1);
                2'b01:   occupancy <= occupancy - occ_width'(1);
                default: occupancy <= occupancy;
            endcase
            // send and return together cancel out
            case ({send, credit_return})
                2'b10:   credits <= credits - credit_width'(1);
                2'b01:   credits <= (credits == '1) ? credits : credits + credit_width'(1);
                default: credits <= credits;
            endcase
            // a dropped result sets overflow until reset
            if (res_valid && !accept) begin
                overflow <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            kind_mem[wr_ptr]  <= res_kind;
            dir_mem[wr_ptr]   <= res_direction;
            count_mem[wr_ptr] <= res_count;
            det_mem[wr_ptr]   <= res_detected;
        end
        if (send) begin
            out_kind      <= kind_mem[rd_ptr];
            out_direction <= dir_mem[rd_ptr];
            out_count     <= count_mem[rd_ptr];
            out_detected  <= det_mem[rd_ptr];
        end
    end

endmodule

// File: logic/zone_classifier.sv
`timescale 1ns/100ps

module zone_classifier #(
    parameter int frame_width  = 320,
    parameter int frame_height = 240,
    parameter int left_end     = 100,
    parameter int right_start  = 295
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                pix_valid,
    input  logic                                is_orange,
    input  logic                                line_active,
    input  logic                                frame_end,
    output logic                                res_valid,
    output steer_pkg::result_kind_t             res_kind,
    output steer_pkg::direction_t               res_direction,
    output logic [steer_pkg::count_width-1:0]   res_count,
    output logic                                res_detected
);

    localparam int cw        = steer_pkg::count_width;
    localparam int col_width = $clog2(frame_width + 1);
    // a frame is detected above a quarter of its pixels
    localparam logic [cw-1:0] threshold = cw'(frame_width * frame_height / 4);

    logic [col_width-1:0] col;
    logic [cw-1:0]        left_cnt;
    logic [cw-1:0]        center_cnt;
    logic [cw-1:0]        right_cnt;
    logic [cw-1:0]        frame_total;
    logic [cw-1:0]        row_count;
    logic                 line_active_d;
    logic                 frame_pending;
    logic                 row_end;
    logic                 frame_fire;
    logic                 orange_hit;
    steer_pkg::direction_t row_dir;

    // falling edge of line_active closes the row
    assign row_end    = line_active_d && !line_active;
    // a frame result waits one cycle if a row result takes this slot
    assign frame_fire = (frame_end || frame_pending) && !row_end;
    assign orange_hit = pix_valid && is_orange;
    assign row_count  = left_cnt + center_cnt + right_cnt;

    // direction priority goes right, then center, then left, else none
    always_comb begin
        if (right_cnt > left_cnt) begin
            row_dir = steer_pkg::dir_right;
        end else if (center_cnt > left_cnt && center_cnt > right_cnt) begin
            row_dir = steer_pkg::dir_center;
        end else if (left_cnt > right_cnt) begin
            row_dir = steer_pkg::dir_left;
        end else begin
            row_dir = steer_pkg::dir_none;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            line_active_d <= 1'b0;
            frame_pending <= 1'b0;
            res_valid     <= 1'b0;
            col           <= '0;
            left_cnt      <= '0;
            center_cnt    <= '0;
            right_cnt     <= '0;
            frame_total   <= '0;
        end else begin
            line_active_d <= line_active;
            res_valid     <= row_end || frame_fire;
            // hold a frame end that collided with a row end
            frame_pending <= (frame_end || frame_pending) && row_end;

            if (row_end) begin
                // zone counters and column restart each row
                col        <= '0;
                left_cnt   <= '0;
                center_cnt <= '0;
                right_cnt  <= '0;
            end else if (pix_valid) begin
                // column saturates so extra pixels fall in no zone
                if (col != col_width'(frame_width)) begin
                    col <= col + col_width'(1);
                end
                if (is_orange) begin
                    if (col < col_width'(left_end)) begin
                        left_cnt <= left_cnt + cw'(1);
                    end else if (col < col_width'(right_start)) begin
                        center_cnt <= center_cnt + cw'(1);
                    end else if (col < col_width'(frame_width)) begin
                        right_cnt <= right_cnt + cw'(1);
                    end
                end
            end

            // total clears when the frame result is taken
            if (frame_fire) begin
                frame_total <= cw'(orange_hit);
            end else if (orange_hit) begin
                frame_total <= frame_total + cw'(1);
            end
        end
    end

    // result payload is valid only with res_valid
    always_ff @(posedge clk) begin
        if (row_end) begin
            res_kind      <= steer_pkg::kind_row;
            res_direction <= row_dir;
            res_count     <= row_count;
            res_detected  <= 1'b0;
        end else if (frame_fire) begin
            res_kind      <= steer_pkg::kind_frame;
            res_direction <= steer_pkg::dir_none;
            res_count     <= frame_total;
            res_detected  <= frame_total > threshold;
        end
    end

endmodule

// File: logic/orange_detect.sv
`timescale 1ns/100ps

module orange_detect (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   pix_valid,
    input  pixel_pkg::pixel_word_t pix_word,
    input  logic                   line_active,
    input  logic                   frame_end,
    output logic                   pix_valid_q,
    output logic                   is_orange,
    output logic                   line_active_q,
    output logic                   frame_end_q
);

    // each channel inside its limit
    logic red_ok;
    logic green_ok;
    logic blue_ok;

    // read the same word through the colour view
    assign red_ok   = pix_word.rgb.red >= pixel_pkg::red_min;
    assign green_ok = (pix_word.rgb.green >= pixel_pkg::green_min) &&
                      (pix_word.rgb.green <= pixel_pkg::green_max);
    assign blue_ok  = pix_word.rgb.blue <= pixel_pkg::blue_max;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pix_valid_q   <= 1'b0;
            is_orange     <= 1'b0;
            line_active_q <= 1'b0;
            frame_end_q   <= 1'b0;
        end else begin
            pix_valid_q   <= pix_valid;
            // only a valid pixel can be orange
            is_orange     <= pix_valid && red_ok && green_ok && blue_ok;
            // markers move with the pixel by the same one cycle
            line_active_q <= line_active;
            frame_end_q   <= frame_end;
        end
    end

endmodule

// File: logic/pixel_capture.sv
`timescale 1ns/100ps

module pixel_capture (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [7:0]             cam_data,
    input  logic                   href,
    input  logic                   vsync,
    output logic                   pix_valid,
    output pixel_pkg::pixel_word_t pix_word,
    output logic                   line_active,
    output logic                   frame_end
);

    // high while the next byte completes a pixel
    logic                 second_byte;
    // first byte of the pair, held until the second one arrives
    pixel_pkg::cam_byte_t hi_byte;
    // previous vsync for edge detection
    logic                 vsync_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            second_byte <= 1'b0;
            pix_valid   <= 1'b0;
            line_active <= 1'b0;
            vsync_q     <= 1'b0;
            frame_end   <= 1'b0;
        end else begin
            // phase restarts whenever href drops
            // so an odd byte at row end cannot shift the next row
            second_byte <= href ? ~second_byte : 1'b0;
            // one cycle after the second byte
            pix_valid   <= href && second_byte;
            // registered href lines up with pix_valid
            line_active <= href;
            vsync_q     <= vsync;
            // single pulse on vsync rising edge
            frame_end   <= vsync && !vsync_q;
        end
    end

    // pixel payload
    always_ff @(posedge clk) begin
        if (href && !second_byte) begin
            hi_byte <= cam_data;
        end
        if (href && second_byte) begin
            // build the word through the byte view
            pix_word.bytes[1] <= hi_byte;
            pix_word.bytes[0] <= cam_data;
        end
    end

endmodule

// File: logic/steer_pkg.sv
package steer_pkg;

    // steering direction reported at the end of each row
    // codes follow the existing classifier output
    typedef enum logic [2:0] {
        dir_none   = 3'd0,
        dir_left   = 3'd1,
        dir_right  = 3'd2,
        dir_center = 3'd3
    } direction_t;

    // what a queued result describes
    typedef enum logic {
        kind_row   = 1'b0,
        kind_frame = 1'b1
    } result_kind_t;

    // width of every count field in a result
    // 18 bits holds a full 320x240 frame total
    localparam int count_width = 18;

endpackage

// File: logic/pixel_pkg.sv
package pixel_pkg;

    // the camera sends RGB444 as two bytes per pixel with the high byte first
    localparam int bytes_per_pixel = 2;

    typedef logic [7:0] cam_byte_t;

    // colour view of a pixel word
    // top nibble of the high byte carries nothing
    typedef struct packed {
        logic [3:0] unused;
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb444_t;

    // one 16 bit word read two ways
    // capture writes it as camera bytes
    // bytes[1] is the high byte
    // detect reads the colour channels from it
    typedef union packed {
        cam_byte_t [bytes_per_pixel-1:0] bytes;
        rgb444_t                         rgb;
    } pixel_word_t;

    // orange colour box with inclusive limits
    localparam logic [3:0] red_min   = 4'hc;
    localparam logic [3:0] green_min = 4'h4;
    localparam logic [3:0] green_max = 4'h9;
    localparam logic [3:0] blue_max  = 4'h4;

endpackage
